/* logic/eth_tx_cfg.svh */
`ifndef ETH_TX_CFG_SVH
`define ETH_TX_CFG_SVH

// datapath geometry, tied to the 64-bit XGMII lane layout
`define ETH_DATA_W      64
`define ETH_KEEP_W      8

// frame limits in bytes
`define ETH_MIN_FRAME   64
`define ETH_FCS_LEN     4

// idle bytes between terminate and the next start, terminate lane included
`define ETH_IFG_MIN     12

// XGMII control characters
`define XGMII_IDLE      8'h07
`define XGMII_START     8'hfb
`define XGMII_TERM      8'hfd

// preamble and start frame delimiter
`define XGMII_PREAMBLE  8'h55
`define XGMII_SFD       8'hd5

// reflected CRC-32 seed
`define CRC_INIT        32'hffff_ffff

`endif

/* logic/eth_tx_pkg.sv */
`include "eth_tx_cfg.svh"

package eth_tx_pkg;

    // one XGMII or stream word
    typedef logic [`ETH_DATA_W-1:0] data_t;

    // one bit per byte lane
    typedef logic [`ETH_KEEP_W-1:0] keep_t;
    typedef logic [`ETH_KEEP_W-1:0] ctrl_t;

    // valid bytes in a beat, 0 to 8
    typedef logic [3:0] byte_cnt_t;

    // byte position inside a frame
    typedef logic [15:0] frame_len_t;

    typedef logic [31:0] crc_t;

    // fcs carries the final CRC and is only meaningful with eof
    typedef struct packed {
        data_t     data;
        byte_cnt_t nbytes;
        logic      sof;
        logic      eof;
        crc_t      fcs;
    } tx_beat_t;

    typedef enum logic [1:0] {
        FR_IDLE,
        FR_PAYLOAD,
        FR_PAD
    } framer_state_t;

    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_DATA,
        ENC_TAIL,
        ENC_GAP
    } enc_state_t;

endpackage

/* logic/axis_beat_capture.sv */
`timescale 1ns/1ps

`include "eth_tx_cfg.svh"

module axis_beat_capture (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_tx_pkg::data_t    s_data,
    input  eth_tx_pkg::keep_t    s_keep,
    input  logic                 s_valid,
    input  logic                 s_last,
    output logic                 s_ready,
    output eth_tx_pkg::tx_beat_t beat,
    output logic                 beat_valid,
    input  logic                 beat_ready
);

    eth_tx_pkg::data_t     masked;
    eth_tx_pkg::byte_cnt_t count;
    logic                  armed_q;
    logic                  in_frame_q;
    logic                  take;

    // clear disabled lanes and count the enabled ones
    always_comb begin
        masked = '0;
        count  = '0;
        for (int i = 0; i < `ETH_KEEP_W; i++) begin
            if (s_keep[i]) begin
                masked[i*8 +: 8] = s_data[i*8 +: 8];
                count = count + 1'b1;
            end
        end
    end

    // armed_q keeps ready low until the first cycle out of reset
    assign s_ready = armed_q && (!beat_valid || beat_ready);
    assign take    = s_valid && s_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed_q    <= 1'b0;
            in_frame_q <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            armed_q <= 1'b1;
            if (take) begin
                beat_valid <= 1'b1;
                in_frame_q <= !s_last;
            end else if (beat_ready) begin
                beat_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            beat.data   <= masked;
            beat.nbytes <= count;
            beat.sof    <= !in_frame_q;
            beat.eof    <= s_last;
            beat.fcs    <= '0;
        end
    end

    // keep fills from lane 0 without holes, and only the last beat is partial
    assert property (@(posedge clk) disable iff (rst)
        s_valid |-> (s_keep != '0) && (((s_keep + 1'b1) & s_keep) == '0)
                    && (s_last || (&s_keep)));

    // no bubbles on the source between first and last beat
    assert property (@(posedge clk) disable iff (rst)
        in_frame_q |-> s_valid);

endmodule

/* logic/crc32_lanes.sv */
`timescale 1ns/1ps

`include "eth_tx_cfg.svh"

module crc32_lanes (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  update,
    input  eth_tx_pkg::data_t     data,
    input  eth_tx_pkg::byte_cnt_t nbytes,
    output eth_tx_pkg::crc_t      crc_next
);

    // reflected form of 0x04c11db7
    localparam eth_tx_pkg::crc_t POLY = 32'hedb8_8320;

    eth_tx_pkg::crc_t crc_q;

    // one byte, lsb first as it goes on the wire
    function automatic eth_tx_pkg::crc_t crc_byte(
        input eth_tx_pkg::crc_t crc_in,
        input logic [7:0]       data_byte
    );
        eth_tx_pkg::crc_t c;
        c = crc_in ^ {24'h0, data_byte};
        for (int k = 0; k < 8; k++) begin
            if (c[0]) begin
                c = (c >> 1) ^ POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // chain over the lanes that carry bytes
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < `ETH_KEEP_W; i++) begin
            if (i < nbytes) begin
                crc_next = crc_byte(crc_next, data[i*8 +: 8]);
            end
        end
    end

    // clear wins so the last beat of a frame re-arms the seed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q <= `CRC_INIT;
        end else if (clear) begin
            crc_q <= `CRC_INIT;
        end else if (update) begin
            crc_q <= crc_next;
        end
    end

endmodule

/* logic/tx_framer.sv */
`timescale 1ns/1ps

`include "eth_tx_cfg.svh"

module tx_framer (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_tx_pkg::tx_beat_t in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output eth_tx_pkg::tx_beat_t out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    // payload bytes a frame needs before the FCS
    localparam eth_tx_pkg::frame_len_t MIN_PAYLOAD = `ETH_MIN_FRAME - `ETH_FCS_LEN;
    localparam eth_tx_pkg::frame_len_t LANES       = `ETH_KEEP_W;

    eth_tx_pkg::framer_state_t state_q;
    eth_tx_pkg::framer_state_t state_d;
    eth_tx_pkg::frame_len_t    len_q;
    eth_tx_pkg::frame_len_t    len_base;
    eth_tx_pkg::frame_len_t    room;
    eth_tx_pkg::tx_beat_t      beat_d;
    eth_tx_pkg::crc_t          crc_next;
    logic                      short_end;
    logic                      pad_mode;
    logic                      xfer;

    // a new frame counts from zero
    assign len_base = (state_q == eth_tx_pkg::FR_IDLE) ? '0 : len_q;
    assign room     = MIN_PAYLOAD - len_base;
    assign xfer     = out_valid && out_ready;

    crc32_lanes u_crc (
        .clk      (clk),
        .rst      (rst),
        .clear    (xfer && beat_d.eof),
        .update   (xfer && !beat_d.eof),
        .data     (beat_d.data),
        .nbytes   (beat_d.nbytes),
        .crc_next (crc_next)
    );

    always_comb begin
        beat_d    = in_beat;
        out_valid = in_valid;
        in_ready  = out_ready;
        short_end = (state_q != eth_tx_pkg::FR_PAD) && in_beat.eof
                    && (len_base + in_beat.nbytes < MIN_PAYLOAD);
        pad_mode  = (state_q == eth_tx_pkg::FR_PAD) || short_end;

        if (state_q == eth_tx_pkg::FR_PAD) begin
            // zero filler, input stays parked in capture
            beat_d    = '0;
            out_valid = 1'b1;
            in_ready  = 1'b0;
        end

        // masked lanes are already zero, so widening nbytes pads in place
        if (pad_mode) begin
            if (room > LANES) begin
                beat_d.nbytes = eth_tx_pkg::byte_cnt_t'(`ETH_KEEP_W);
                beat_d.eof    = 1'b0;
            end else begin
                beat_d.nbytes = room[3:0];
                beat_d.eof    = 1'b1;
            end
        end
    end

    // FCS goes on the wire inverted
    always_comb begin
        out_beat     = beat_d;
        out_beat.fcs = beat_d.eof ? ~crc_next : '0;
    end

    always_comb begin
        state_d = state_q;
        if (xfer) begin
            if (beat_d.eof) begin
                state_d = eth_tx_pkg::FR_IDLE;
            end else if (pad_mode) begin
                state_d = eth_tx_pkg::FR_PAD;
            end else begin
                state_d = eth_tx_pkg::FR_PAYLOAD;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= eth_tx_pkg::FR_IDLE;
            len_q   <= '0;
        end else begin
            state_q <= state_d;
            if (xfer) begin
                len_q <= len_base + beat_d.nbytes;
            end
        end
    end

    // a stalled beat, pad or passed through, must not change under the encoder
    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)));

endmodule

/* logic/xgmii_encoder.sv */
`timescale 1ns/1ps

`include "eth_tx_cfg.svh"

module xgmii_encoder (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_tx_pkg::tx_beat_t beat,
    input  logic                 beat_valid,
    output logic                 beat_ready,
    output eth_tx_pkg::data_t    xgmii_txd,
    output eth_tx_pkg::ctrl_t    xgmii_txc
);

    localparam eth_tx_pkg::data_t IDLE_WORD = {`ETH_KEEP_W{`XGMII_IDLE}};
    localparam eth_tx_pkg::data_t START_WORD =
        {`XGMII_SFD, {(`ETH_KEEP_W-2){`XGMII_PREAMBLE}}, `XGMII_START};
    localparam eth_tx_pkg::ctrl_t START_CTRL = {{(`ETH_KEEP_W-1){1'b0}}, 1'b1};
    localparam eth_tx_pkg::frame_len_t LANES   = `ETH_KEEP_W;
    localparam eth_tx_pkg::frame_len_t IFG_MIN = `ETH_IFG_MIN;

    eth_tx_pkg::enc_state_t   state_q;
    eth_tx_pkg::enc_state_t   state_d;
    eth_tx_pkg::tx_beat_t     hold_q;
    eth_tx_pkg::data_t        tail_q;
    eth_tx_pkg::ctrl_t        tail_c_q;
    eth_tx_pkg::frame_len_t   gap_q;
    eth_tx_pkg::frame_len_t   gap_d;
    eth_tx_pkg::data_t        txd_d;
    eth_tx_pkg::ctrl_t        txc_d;
    eth_tx_pkg::byte_cnt_t    term_pos;
    eth_tx_pkg::frame_len_t   term_idle;
    logic [2*`ETH_DATA_W-1:0] body;
    logic [2*`ETH_DATA_W-1:0] term_d;
    logic [2*`ETH_KEEP_W-1:0] term_c;
    logic                     load_hold;

    // last data, FCS, terminate and idles laid out over two words
    always_comb begin
        term_pos  = hold_q.nbytes + eth_tx_pkg::byte_cnt_t'(`ETH_FCS_LEN);
        term_idle = LANES - eth_tx_pkg::frame_len_t'(term_pos[2:0]);
        body = {{`ETH_DATA_W{1'b0}}, hold_q.data}
             | ({{(2*`ETH_DATA_W-32){1'b0}}, hold_q.fcs} << {hold_q.nbytes, 3'b000});
        for (int i = 0; i < 2*`ETH_KEEP_W; i++) begin
            if (i < term_pos) begin
                term_d[i*8 +: 8] = body[i*8 +: 8];
                term_c[i]        = 1'b0;
            end else if (i == term_pos) begin
                term_d[i*8 +: 8] = `XGMII_TERM;
                term_c[i]        = 1'b1;
            end else begin
                term_d[i*8 +: 8] = `XGMII_IDLE;
                term_c[i]        = 1'b1;
            end
        end
    end

    always_comb begin
        state_d    = state_q;
        gap_d      = gap_q;
        txd_d      = IDLE_WORD;
        txc_d      = '1;
        beat_ready = 1'b0;
        load_hold  = 1'b0;
        case (state_q)
            eth_tx_pkg::ENC_IDLE: begin
                beat_ready = 1'b1;
                if (beat_valid) begin
                    load_hold = 1'b1;
                    txd_d     = START_WORD;
                    txc_d     = START_CTRL;
                    state_d   = eth_tx_pkg::ENC_DATA;
                end
            end
            eth_tx_pkg::ENC_DATA: begin
                if (!hold_q.eof) begin
                    beat_ready = 1'b1;
                    load_hold  = beat_valid;
                    txd_d      = hold_q.data;
                    txc_d      = '0;
                end else begin
                    txd_d = term_d[`ETH_DATA_W-1:0];
                    txc_d = term_c[`ETH_KEEP_W-1:0];
                    // idles still owed once the terminate word is out
                    gap_d = (IFG_MIN > term_idle) ? IFG_MIN - term_idle : '0;
                    if (term_pos >= `ETH_KEEP_W) begin
                        state_d = eth_tx_pkg::ENC_TAIL;
                    end else if (gap_d != '0) begin
                        state_d = eth_tx_pkg::ENC_GAP;
                    end else begin
                        state_d = eth_tx_pkg::ENC_IDLE;
                    end
                end
            end
            eth_tx_pkg::ENC_TAIL: begin
                txd_d   = tail_q;
                txc_d   = tail_c_q;
                state_d = (gap_q != '0) ? eth_tx_pkg::ENC_GAP : eth_tx_pkg::ENC_IDLE;
            end
            default: begin
                if (gap_q <= LANES) begin
                    gap_d   = '0;
                    state_d = eth_tx_pkg::ENC_IDLE;
                end else begin
                    gap_d = gap_q - LANES;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= eth_tx_pkg::ENC_IDLE;
            gap_q     <= '0;
            xgmii_txd <= IDLE_WORD;
            xgmii_txc <= '1;
        end else begin
            state_q   <= state_d;
            gap_q     <= gap_d;
            xgmii_txd <= txd_d;
            xgmii_txc <= txc_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_hold) begin
            hold_q <= beat;
        end
        if (state_q == eth_tx_pkg::ENC_DATA) begin
            tail_q   <= term_d[2*`ETH_DATA_W-1:`ETH_DATA_W];
            tail_c_q <= term_c[2*`ETH_KEEP_W-1:`ETH_KEEP_W];
        end
    end

    // only the next frame's first beat may be waiting out the gap
    assert property (@(posedge clk) disable iff (rst)
        (state_q == eth_tx_pkg::ENC_GAP && beat_valid) |-> beat.sof);

endmodule

/* logic/eth_mac_tx.sv */
`timescale 1ns/1ps

module eth_mac_tx (
    input  logic              clk,
    input  logic              rst,
    input  eth_tx_pkg::data_t s_data,
    input  eth_tx_pkg::keep_t s_keep,
    input  logic              s_valid,
    input  logic              s_last,
    output logic              s_ready,
    output eth_tx_pkg::data_t xgmii_txd,
    output eth_tx_pkg::ctrl_t xgmii_txc
);

    eth_tx_pkg::tx_beat_t cap_beat;
    logic                 cap_valid;
    logic                 cap_ready;
    eth_tx_pkg::tx_beat_t enc_beat;
    logic                 enc_valid;
    logic                 enc_ready;

    axis_beat_capture u_capture (
        .clk        (clk),
        .rst        (rst),
        .s_data     (s_data),
        .s_keep     (s_keep),
        .s_valid    (s_valid),
        .s_last     (s_last),
        .s_ready    (s_ready),
        .beat       (cap_beat),
        .beat_valid (cap_valid),
        .beat_ready (cap_ready)
    );

    // padding and FCS
    tx_framer u_framer (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (cap_beat),
        .in_valid  (cap_valid),
        .in_ready  (cap_ready),
        .out_beat  (enc_beat),
        .out_valid (enc_valid),
        .out_ready (enc_ready)
    );

    xgmii_encoder u_encoder (
        .clk        (clk),
        .rst        (rst),
        .beat       (enc_beat),
        .beat_valid (enc_valid),
        .beat_ready (enc_ready),
        .xgmii_txd  (xgmii_txd),
        .xgmii_txc  (xgmii_txc)
    );

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // held over three rising edges, released just after the third
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* sim/eth_mac_tx_tb.sv */
`timescale 1ns/1ps

`include "eth_tx_cfg.svh"

module eth_mac_tx_tb;

    localparam int NUM_FRAMES = 24;
    localparam int MIN_PAY    = `ETH_MIN_FRAME - `ETH_FCS_LEN;
    // short frames and every final byte count from 1 to 8
    localparam int DIRECTED [12] = '{1, 8, 45, 59, 60, 61, 62, 63, 64, 65, 66, 67};
    localparam eth_tx_pkg::data_t IDLE_WORD = {8{`XGMII_IDLE}};
    localparam eth_tx_pkg::data_t START_WORD =
        {`XGMII_SFD, {6{`XGMII_PREAMBLE}}, `XGMII_START};

    logic              clk;
    logic              rst;
    eth_tx_pkg::data_t s_data;
    eth_tx_pkg::keep_t s_keep;
    logic              s_valid;
    logic              s_last;
    logic              s_ready;
    eth_tx_pkg::data_t xgmii_txd;
    eth_tx_pkg::ctrl_t xgmii_txc;

    integer           seed;
    int               len_tab [NUM_FRAMES];
    logic [7:0]       pay_buf [256];
    logic [7:0]       exp_bytes [$];
    eth_tx_pkg::crc_t exp_fcs [$];
    int               exp_len [$];
    logic [7:0]       rx_bytes [$];
    int               frames_done = 0;
    int               gap_bytes = 0;
    logic             in_frame = 1'b0;
    longint           timeout_ns = 0;

    tb_clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    eth_mac_tx u_dut (
        .clk       (clk),
        .rst       (rst),
        .s_data    (s_data),
        .s_keep    (s_keep),
        .s_valid   (s_valid),
        .s_last    (s_last),
        .s_ready   (s_ready),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc)
    );

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input eth_tx_pkg::data_t got,
                              input eth_tx_pkg::data_t exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input string name, input eth_tx_pkg::ctrl_t got,
                              input eth_tx_pkg::ctrl_t exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_fcs(input string name, input eth_tx_pkg::crc_t got,
                             input eth_tx_pkg::crc_t exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_len(input string name, input eth_tx_pkg::frame_len_t got,
                             input eth_tx_pkg::frame_len_t lo,
                             input eth_tx_pkg::frame_len_t hi);
        if (got < lo || got > hi) begin
            $display("error %s: got %h expected %h to %h", name, got, lo, hi);
            abort_run();
        end
    endtask

    // bit-serial reflected CRC-32 over pay_buf and complemented for the wire
    function automatic eth_tx_pkg::crc_t ref_fcs(input int n);
        eth_tx_pkg::crc_t c;
        logic [7:0]       b;
        c = `CRC_INIT;
        for (int i = 0; i < n; i++) begin
            b = pay_buf[i];
            for (int k = 0; k < 8; k++) begin
                c = (c[0] ^ b[k]) ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    // holds the beat until ready is seen on a falling edge
    task automatic send_beat(input eth_tx_pkg::data_t d, input eth_tx_pkg::keep_t k,
                             input logic last);
        logic taken;
        s_data  = d;
        s_keep  = k;
        s_last  = last;
        s_valid = 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = s_ready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_frame(input int n);
        int                plen;
        eth_tx_pkg::data_t d;
        eth_tx_pkg::keep_t k;
        plen = (n < MIN_PAY) ? MIN_PAY : n;
        for (int i = 0; i < plen; i++) begin
            pay_buf[i] = (i < n) ? 8'($random(seed)) : 8'h00;
            exp_bytes.push_back(pay_buf[i]);
        end
        exp_fcs.push_back(ref_fcs(plen));
        exp_len.push_back(plen);
        for (int b = 0; b < n; b += 8) begin
            for (int i = 0; i < 8; i++) begin
                // junk in disabled lanes must never reach the wire
                d[i*8 +: 8] = (b + i < n) ? pay_buf[b + i] : 8'hee;
                k[i]        = (b + i < n);
            end
            send_beat(d, k, (b + 8 >= n));
        end
    endtask

    task automatic finish_frame();
        int                plen;
        eth_tx_pkg::data_t got_w;
        eth_tx_pkg::data_t exp_w;
        eth_tx_pkg::crc_t  got_fcs;
        if (exp_len.size() == 0) begin
            $display("a frame arrived on XGMII when no frame was expected");
            abort_run();
        end
        plen = exp_len.pop_front();
        check_len("xgmii frame bytes", rx_bytes.size(), plen + 4, plen + 4);
        for (int b = 0; b < plen; b += 8) begin
            got_w = '0;
            exp_w = '0;
            for (int i = 0; i < 8 && b + i < plen; i++) begin
                got_w[i*8 +: 8] = rx_bytes[b + i];
                exp_w[i*8 +: 8] = exp_bytes.pop_front();
            end
            check_data("xgmii_txd payload", got_w, exp_w);
        end
        for (int i = 0; i < 4; i++) begin
            got_fcs[i*8 +: 8] = rx_bytes[plen + i];
        end
        check_fcs("xgmii_txd fcs", got_fcs, exp_fcs.pop_front());
        rx_bytes.delete();
        in_frame = 1'b0;
        frames_done++;
    endtask

    task automatic parse_word(input eth_tx_pkg::data_t d, input eth_tx_pkg::ctrl_t c);
        int                term;
        eth_tx_pkg::data_t got_w;
        eth_tx_pkg::data_t exp_w;
        eth_tx_pkg::ctrl_t exp_c;
        term  = 8;
        got_w = '0;
        exp_w = '0;
        if (!in_frame) begin
            if (d == IDLE_WORD && c == '1) begin
                gap_bytes += 8;
            end else begin
                check_ctrl("xgmii_txc start", c, 8'h01);
                check_data("xgmii_txd start", d, START_WORD);
                if (frames_done > 0) begin
                    check_len("ifg bytes", gap_bytes, `ETH_IFG_MIN, `ETH_IFG_MIN + 7);
                end
                in_frame = 1'b1;
            end
        end else begin
            // lowest control lane holds the terminate
            for (int i = 7; i >= 0; i--) begin
                if (c[i]) begin
                    term = i;
                end
            end
            for (int i = 0; i < 8; i++) begin
                if (i < term) begin
                    rx_bytes.push_back(d[i*8 +: 8]);
                    exp_c[i] = 1'b0;
                end else begin
                    got_w[i*8 +: 8] = d[i*8 +: 8];
                    exp_w[i*8 +: 8] = (i == term) ? `XGMII_TERM : `XGMII_IDLE;
                    exp_c[i]        = 1'b1;
                end
            end
            check_ctrl("xgmii_txc", c, exp_c);
            if (term < 8) begin
                check_data("xgmii_txd terminate", got_w, exp_w);
                gap_bytes = 8 - term;
                finish_frame();
            end
        end
    endtask

    // XGMII monitor sampling on the falling edge
    initial begin
        #1;
        forever begin
            @(negedge clk);
            if (rst) begin
                check_data("xgmii_txd", xgmii_txd, IDLE_WORD);
                check_ctrl("xgmii_txc", xgmii_txc, '1);
                if (s_ready !== 1'b0) begin
                    $display("error s_ready: got %h expected %h", s_ready, 1'b0);
                    abort_run();
                end
            end else begin
                parse_word(xgmii_txd, xgmii_txc);
            end
        end
    end

    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("timeout: XGMII stopped delivering frames before the test was done");
        abort_run();
    end

    initial begin
        longint words;
        seed    = 32'h08789d8d;
        s_data  = '0;
        s_keep  = '1;
        s_valid = 1'b0;
        s_last  = 1'b0;
        words   = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            len_tab[f] = (f < 12) ? DIRECTED[f] : 1 + ($unsigned($random(seed)) % 200);
            // frame words plus start and gap allowance
            words += ((len_tab[f] < MIN_PAY ? MIN_PAY : len_tab[f]) + 4 + 7) / 8 + 4;
        end
        timeout_ns = words * 4 * 2 + 100;
        wait (rst === 1'b0);
        repeat (2) @(posedge clk);
        #1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(len_tab[f]);
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
        wait (frames_done == NUM_FRAMES);
        // long enough for a stray start to show up after the last gap
        repeat (8) @(posedge clk);
        if (!in_frame) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("XGMII started another frame after the last expected one");
            abort_run();
        end
    end

endmodule

/* src.f */
+incdir+logic
logic/eth_tx_pkg.sv
logic/axis_beat_capture.sv
logic/crc32_lanes.sv
logic/tx_framer.sv
logic/xgmii_encoder.sv
logic/eth_mac_tx.sv
sim/tb_clk_gen.sv
sim/eth_mac_tx_tb.sv

/* Bender.yml */
package:
  name: eth_mac_tx

sources:
  - include_dirs:
      - logic
    files:
      - logic/eth_tx_pkg.sv
      - logic/axis_beat_capture.sv
      - logic/crc32_lanes.sv
      - logic/tx_framer.sv
      - logic/xgmii_encoder.sv
      - logic/eth_mac_tx.sv

  - target: test
    include_dirs:
      - logic
    files:
      - sim/tb_clk_gen.sv
      - sim/eth_mac_tx_tb.sv
